//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_set_cache
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
SRCS      := $(filter %.sv %.v,$(shell cat $(FLIST)))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cache_array.sv
`timescale 1ns/100ps

module cache_array import cache_pkg::*; #(
	parameter int NUM_SETS = 16
) (
	input  logic clk,
	input  logic reset,
	input  logic [BUS_DATA_WIDTH-1:0] addr,
	input  array_wr_t wr,
	input  line_t wr_line,
	output lookup_t lookup,
	output line_t rd_line
);

	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = BUS_DATA_WIDTH - OFFSET_BITS - INDEX_BITS;

	logic [TAG_BITS-1:0] tags [2][NUM_SETS];
	line_t data [2][NUM_SETS];
	logic [1:0][NUM_SETS-1:0] valid;
	logic [1:0][NUM_SETS-1:0] dirty;
	logic [NUM_SETS-1:0] recent; // most recently used way per set

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic hit0;
	logic hit1;
	logic vway;
	logic rd_way;

	assign index = addr[OFFSET_BITS +: INDEX_BITS];
	assign tag = addr[BUS_DATA_WIDTH-1 -: TAG_BITS];

	// tag compare on both ways
	assign hit0 = valid[0][index] && (tags[0][index] == tag);
	assign hit1 = valid[1][index] && (tags[1][index] == tag);

	// victim selection
	always_comb begin
		if (!valid[0][index])
			vway = 1'b0; // empty way first
		else if (!valid[1][index])
			vway = 1'b1;
		else
			vway = !recent[index]; // otherwise the LRU way
	end

	always_comb begin
		lookup.hit = hit0 || hit1;
		lookup.hit_way = hit1;
		lookup.victim_way = vway;
		lookup.victim_valid = valid[vway][index];
		lookup.victim_dirty = dirty[vway][index];
		lookup.victim_tag = {tags[vway][index], index};
	end

	assign rd_way = (hit0 || hit1) ? hit1 : vway;
	assign rd_line = data[rd_way][index]; // hit line, or the victim on a miss

	// status bits
	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			dirty <= '0;
			recent <= '0;
		end else begin
			if (wr.en) begin
				valid[wr.way][index] <= 1'b1;
				dirty[wr.way][index] <= wr.dirty;
			end
			if (wr.touch)
				recent[index] <= wr.way;
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (wr.en) begin
			tags[wr.way][index] <= tag;
			data[wr.way][index] <= wr_line;
		end
	end

endmodule

//--- cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl import cache_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic p_bus_reqcyc,
	input  logic p_bus_respack,
	input  logic m_bus_reqack,
	input  logic m_bus_respcyc,
	input  logic [BUS_DATA_WIDTH-1:0] p_bus_req,
	input  logic [BUS_TAG_WIDTH-1:0] p_bus_reqtag,
	output logic p_bus_reqack,
	output logic p_bus_respcyc,
	output logic m_bus_reqcyc,
	output logic m_bus_respack,
	output logic [BUS_TAG_WIDTH-1:0] p_bus_resptag,
	output logic [BUS_TAG_WIDTH-1:0] m_bus_reqtag,
	output logic [BUS_DATA_WIDTH-1:0] m_bus_req,
	output logic [BUS_DATA_WIDTH-1:0] req_addr,
	input  lookup_t lookup,
	output array_wr_t arr_wr,
	output logic buf_load_beat,
	output logic buf_load_line,
	output logic buf_clear,
	output logic buf_step,
	input  logic [BUS_DATA_WIDTH-1:0] beat,
	input  logic beat_last
);

	cache_state_t state;
	cache_state_t next_state;
	logic [BUS_TAG_WIDTH-1:0] req_tag;
	logic [BUS_DATA_WIDTH-OFFSET_BITS-1:0] wb_line; // victim line address, kept for writeback
	logic way_q;    // way picked in lookup, used by update
	logic is_read;
	logic need_wb;

	assign is_read = req_tag[REQ_READ_BIT];
	assign need_wb = lookup.victim_valid && lookup.victim_dirty;
	assign p_bus_resptag = req_tag;

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_accept;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (state == st_accept && p_bus_reqcyc) begin
			req_addr <= p_bus_req;
			req_tag <= p_bus_reqtag;
		end
		if (state == st_lookup) begin
			way_q <= lookup.hit ? lookup.hit_way : lookup.victim_way;
			wb_line <= lookup.victim_tag; // array contents may change before the writeback
		end
	end

	// dram address phase carries the line address, data phase the buffered beat
	always_comb begin
		m_bus_reqtag = req_tag;
		m_bus_reqtag[REQ_READ_BIT] = !(state == st_wb_req || state == st_wb_data);
		if (state == st_wb_data)
			m_bus_req = beat;
		else if (state == st_wb_req)
			m_bus_req = {wb_line, {OFFSET_BITS{1'b0}}};
		else
			m_bus_req = {req_addr[BUS_DATA_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	end

	always_comb begin
		next_state = state;
		p_bus_reqack = 1'b0;
		p_bus_respcyc = 1'b0;
		m_bus_reqcyc = 1'b0;
		m_bus_respack = 1'b0;
		buf_load_beat = 1'b0;
		buf_load_line = 1'b0;
		buf_clear = 1'b0;
		buf_step = 1'b0;
		arr_wr = '0;
		case (state)
			st_accept: begin
				if (p_bus_reqcyc)
					next_state = st_ack_req;
			end
			st_ack_req: begin
				p_bus_reqack = 1'b1;
				buf_clear = 1'b1; // beat pointer back to 0
				next_state = is_read ? st_lookup : st_read_val;
			end
			st_read_val: begin
				if (p_bus_reqcyc) begin
					buf_load_beat = 1'b1;
					next_state = st_ack_val;
				end
			end
			st_ack_val: begin
				p_bus_reqack = 1'b1;
				buf_step = 1'b1;
				next_state = beat_last ? st_lookup : st_read_val;
			end
			st_lookup: begin
				if (lookup.hit && is_read) begin
					buf_load_line = 1'b1;
					arr_wr.way = lookup.hit_way;
					arr_wr.touch = 1'b1;
					next_state = st_respond; // respcyc 2 cycles after reqack
				end else if (lookup.hit) begin
					next_state = st_update;
				end else if (need_wb) begin
					// victim line moves into the buffer
					buf_load_line = 1'b1;
					if (!is_read) begin
						// same edge: write data goes into the victim way (swap)
						arr_wr.en = 1'b1;
						arr_wr.way = lookup.victim_way;
						arr_wr.dirty = 1'b1;
						arr_wr.touch = 1'b1;
					end
					next_state = st_wb_req;
				end else begin
					next_state = is_read ? st_fill_req : st_update;
				end
			end
			st_wb_req: begin
				m_bus_reqcyc = 1'b1;
				if (m_bus_reqack)
					next_state = st_wb_data;
			end
			st_wb_data: begin
				m_bus_reqcyc = 1'b1;
				if (m_bus_reqack) begin
					buf_step = 1'b1;
					if (beat_last)
						next_state = is_read ? st_fill_req : st_accept;
				end
			end
			st_fill_req: begin
				m_bus_reqcyc = 1'b1;
				if (m_bus_reqack)
					next_state = st_fill_data;
			end
			st_fill_data: begin
				if (m_bus_respcyc) begin
					m_bus_respack = 1'b1; // taken this cycle
					buf_load_beat = 1'b1;
					buf_step = 1'b1;
					if (beat_last)
						next_state = st_update;
				end
			end
			st_update: begin
				arr_wr.en = 1'b1;
				arr_wr.way = way_q;
				arr_wr.dirty = !is_read;
				arr_wr.touch = 1'b1;
				next_state = is_read ? st_respond : st_accept;
			end
			st_respond: begin
				p_bus_respcyc = 1'b1; // held until respack
				if (p_bus_respack) begin
					buf_step = 1'b1;
					next_state = beat_last ? st_accept : st_resp_wait;
				end
			end
			st_resp_wait: next_state = st_respond;
			default: next_state = st_accept;
		endcase
	end

endmodule

//--- cache_pkg.sv
package cache_pkg;

	// sysbus field widths
	localparam int BUS_DATA_WIDTH = 64;
	localparam int BUS_TAG_WIDTH = 13;
	localparam int REQ_READ_BIT = 12; // 1 = read request, 0 = write request

	// line geometry
	localparam int BEATS = 8;
	localparam int LINE_WIDTH = 512;
	localparam int OFFSET_BITS = 6; // byte offset inside one 64-byte line

	typedef logic [LINE_WIDTH-1:0] line_t;

	// controller states
	typedef enum logic [3:0] {
		st_accept,    // idle, waiting for a processor request
		st_ack_req,   // reqack for the address phase
		st_read_val,  // take one write beat from the processor
		st_ack_val,   // reqack for that beat
		st_lookup,    // tag compare on the registered address
		st_wb_req,    // writeback address phase to dram
		st_wb_data,   // writeback data beats
		st_fill_req,  // fill address phase to dram
		st_fill_data, // fill beats coming back
		st_update,    // write the line into the array
		st_respond,   // one read beat on the processor port
		st_resp_wait  // respcyc low between beats
	} cache_state_t;

	// array -> controller
	typedef struct packed {
		logic hit;
		logic hit_way;
		logic victim_way;
		logic victim_valid;
		logic victim_dirty;
		// victim line address above the offset bits (tag and set index)
		logic [BUS_DATA_WIDTH-OFFSET_BITS-1:0] victim_tag;
	} lookup_t;

	// controller -> array
	typedef struct packed {
		logic en;    // write tag, data, valid and dirty of one way
		logic way;
		logic dirty; // dirty value written with en
		logic touch; // mark way as most recently used
	} array_wr_t;

endpackage

//--- dram_model.sv
`timescale 1ns/100ps

module dram_model import cache_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic m_bus_reqcyc,
	output logic m_bus_reqack,
	input  logic [BUS_DATA_WIDTH-1:0] m_bus_req,
	input  logic [BUS_TAG_WIDTH-1:0] m_bus_reqtag,
	output logic m_bus_respcyc,
	input  logic m_bus_respack,
	output logic [BUS_DATA_WIDTH-1:0] m_bus_resp,
	output logic [BUS_TAG_WIDTH-1:0] m_bus_resptag,
	output int fill_count,
	output int wb_count,
	output logic [BUS_DATA_WIDTH-1:0] last_wb_addr
);

	typedef enum {ph_idle, ph_wb, ph_fill} phase_t;

	logic [BUS_DATA_WIDTH-1:0] mem [logic [60:0]]; // written beats, key is line and beat
	phase_t phase;
	logic [57:0] line;
	int beat_idx;

	// beats never written keep the line address xor beat number
	function automatic logic [BUS_DATA_WIDTH-1:0] mem_read(input logic [57:0] ln, input int b);
		logic [60:0] key;
		key = {ln, 3'(b)};
		if (mem.exists(key))
			return mem[key];
		return {ln, 6'b0} ^ 64'(b);
	endfunction

	initial begin
		m_bus_reqack = 1'b0;
		m_bus_respcyc = 1'b0;
		m_bus_resp = '0;
		m_bus_resptag = '0;
		fill_count = 0;
		wb_count = 0;
		last_wb_addr = '0;
		phase = ph_idle;
		line = '0;
		beat_idx = 0;
		forever begin
			@(posedge clk);
			#10;
			m_bus_reqack = 1'b0;
			m_bus_respcyc = 1'b0;
			if (!reset && m_bus_reqcyc && phase != ph_fill)
				m_bus_reqack = ($urandom_range(0, 2) == 0); // short random wait
			if (phase == ph_fill) begin
				m_bus_respcyc = ($urandom_range(0, 1) == 0);
				m_bus_resp = mem_read(line, beat_idx);
			end
			@(negedge clk); // handshakes settle mid cycle
			if (m_bus_reqcyc && m_bus_reqack) begin
				if (phase == ph_idle) begin
					line = m_bus_req[63:6];
					beat_idx = 0;
					if (m_bus_reqtag[REQ_READ_BIT]) begin
						phase = ph_fill;
						fill_count++;
						m_bus_resptag = m_bus_reqtag;
					end else begin
						phase = ph_wb;
						wb_count++;
						last_wb_addr = m_bus_req;
					end
				end else begin
					mem[{line, 3'(beat_idx)}] = m_bus_req; // writeback beat
					beat_idx++;
					if (beat_idx == BEATS)
						phase = ph_idle;
				end
			end else if (m_bus_respcyc && m_bus_respack) begin
				beat_idx++;
				if (beat_idx == BEATS)
					phase = ph_idle;
			end
		end
	end

endmodule

//--- flist.f
cache_pkg.sv
line_buffer.sv
cache_array.sv
cache_ctrl.sv
set_cache.sv
set_cache_assertions.sv
dram_model.sv
tb_clock_gen.sv
tb_set_cache.sv

//--- line_buffer.sv
`timescale 1ns/100ps

module line_buffer import cache_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic load_beat,
	input  logic load_line,
	input  logic clear,
	input  logic step,
	input  logic [BUS_DATA_WIDTH-1:0] beat_in,
	input  line_t line_in,
	output line_t line_out,
	output logic [BUS_DATA_WIDTH-1:0] beat_out,
	output logic beat_last
);

	logic [BEATS-1:0][BUS_DATA_WIDTH-1:0] line_q; // beat 0 in the low bits
	logic [$clog2(BEATS)-1:0] ptr;

	// beat pointer, wraps after beat 7
	always_ff @(posedge clk) begin
		if (reset)
			ptr <= '0;
		else if (clear || load_line)
			ptr <= '0; // a new line always starts at beat 0
		else if (step)
			ptr <= ptr + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (load_line)
			line_q <= line_in;
		else if (load_beat)
			line_q[ptr] <= beat_in;
	end

	assign line_out = line_q;
	assign beat_out = line_q[ptr];
	assign beat_last = (ptr == $clog2(BEATS)'(BEATS-1));

endmodule

//--- set_cache.sv
`timescale 1ns/100ps

module set_cache import cache_pkg::*; #(
	parameter int NUM_SETS = 16
) (
	input  logic clk,
	input  logic reset,

	// processor side
	input  logic p_bus_reqcyc,
	output logic p_bus_reqack,
	input  logic [BUS_DATA_WIDTH-1:0] p_bus_req,
	input  logic [BUS_TAG_WIDTH-1:0] p_bus_reqtag,
	output logic p_bus_respcyc,
	input  logic p_bus_respack,
	output logic [BUS_DATA_WIDTH-1:0] p_bus_resp,
	output logic [BUS_TAG_WIDTH-1:0] p_bus_resptag,

	// dram side
	output logic m_bus_reqcyc,
	input  logic m_bus_reqack,
	output logic [BUS_DATA_WIDTH-1:0] m_bus_req,
	output logic [BUS_TAG_WIDTH-1:0] m_bus_reqtag,
	input  logic m_bus_respcyc,
	output logic m_bus_respack,
	input  logic [BUS_DATA_WIDTH-1:0] m_bus_resp,
	input  logic [BUS_TAG_WIDTH-1:0] m_bus_resptag // single outstanding fill, tag not checked
);

	logic [BUS_DATA_WIDTH-1:0] req_addr;
	lookup_t lookup;
	array_wr_t arr_wr;
	line_t rd_line;
	line_t buf_line;
	logic buf_load_beat;
	logic buf_load_line;
	logic buf_clear;
	logic buf_step;
	logic [BUS_DATA_WIDTH-1:0] buf_beat;
	logic [BUS_DATA_WIDTH-1:0] buf_beat_in;
	logic beat_last;

	// fill beats while respack is up, processor write beats otherwise
	assign buf_beat_in = m_bus_respack ? m_bus_resp : p_bus_req;
	assign p_bus_resp = buf_beat;

	cache_ctrl i_ctrl (
		.clk, .reset,
		.p_bus_reqcyc, .p_bus_respack, .m_bus_reqack, .m_bus_respcyc,
		.p_bus_req, .p_bus_reqtag,
		.p_bus_reqack, .p_bus_respcyc, .m_bus_reqcyc, .m_bus_respack,
		.p_bus_resptag, .m_bus_reqtag, .m_bus_req,
		.req_addr, .lookup, .arr_wr,
		.buf_load_beat, .buf_load_line, .buf_clear, .buf_step,
		.beat(buf_beat), .beat_last
	);

	cache_array #(.NUM_SETS(NUM_SETS)) i_array (
		.clk, .reset,
		.addr(req_addr), .wr(arr_wr), .wr_line(buf_line),
		.lookup, .rd_line
	);

	line_buffer i_buf (
		.clk, .reset,
		.load_beat(buf_load_beat), .load_line(buf_load_line),
		.clear(buf_clear), .step(buf_step),
		.beat_in(buf_beat_in), .line_in(rd_line),
		.line_out(buf_line), .beat_out(buf_beat), .beat_last
	);

endmodule

//--- set_cache_assertions.sv
`timescale 1ns/100ps

module set_cache_assertions import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input logic p_bus_reqack,
	input logic p_bus_respcyc,
	input logic p_bus_respack,
	input logic [BUS_DATA_WIDTH-1:0] p_bus_resp,
	input logic m_bus_reqcyc,
	input logic m_bus_reqack,
	input logic [BUS_DATA_WIDTH-1:0] m_bus_req,
	input logic [BUS_TAG_WIDTH-1:0] m_bus_reqtag,
	input logic m_bus_respack
);

	int failures = 0; // read by the testbench top

	a_reqack_pulse: assert property (@(posedge clk) disable iff (reset)
		p_bus_reqack |=> !p_bus_reqack)
	else begin
		$error("p_bus_reqack high for more than one cycle");
		failures++;
	end

	// read beat held until the processor takes it
	a_resp_stable: assert property (@(posedge clk) disable iff (reset)
		p_bus_respcyc && !p_bus_respack |=> p_bus_respcyc && $stable(p_bus_resp))
	else begin
		$error("p_bus_respcyc or p_bus_resp changed before respack");
		failures++;
	end

	a_mreq_stable: assert property (@(posedge clk) disable iff (reset)
		m_bus_reqcyc && !m_bus_reqack |=>
			m_bus_reqcyc && $stable(m_bus_req) && $stable(m_bus_reqtag))
	else begin
		$error("dram request changed before reqack");
		failures++;
	end

	a_reset_quiet: assert property (@(posedge clk)
		reset |=> !(p_bus_reqack || p_bus_respcyc || m_bus_reqcyc || m_bus_respack))
	else begin
		$error("cyc or ack output high right after reset");
		failures++;
	end

endmodule

bind set_cache set_cache_assertions i_assertions (
	.clk, .reset, .p_bus_reqack, .p_bus_respcyc, .p_bus_respack, .p_bus_resp,
	.m_bus_reqcyc, .m_bus_reqack, .m_bus_req, .m_bus_reqtag, .m_bus_respack
);

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// reset released just after the edge, like the other stimulus
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		reset = 1'b0;
	end

endmodule

//--- tb_set_cache.sv
`timescale 1ns/100ps

module tb_set_cache import cache_pkg::*; ();

	localparam int TIMEOUT = 200; // cycles per wait
	localparam logic [63:0] LINE_A1 = 64'h1040; // set 1
	localparam logic [63:0] LINE_LA = 64'h2080; // set 2, three tags
	localparam logic [63:0] LINE_LB = 64'h2480;
	localparam logic [63:0] LINE_LC = 64'h2880;
	localparam logic [63:0] LINE_WA = 64'h30c0; // set 3, three tags
	localparam logic [63:0] LINE_WX = 64'h34c0;
	localparam logic [63:0] LINE_WY = 64'h38c0;
	localparam logic [63:0] LINE_BP = 64'h5140; // set 5

	logic clk;
	logic reset;
	logic p_bus_reqcyc;
	logic p_bus_reqack;
	logic [BUS_DATA_WIDTH-1:0] p_bus_req;
	logic [BUS_TAG_WIDTH-1:0] p_bus_reqtag;
	logic p_bus_respcyc;
	logic p_bus_respack;
	logic [BUS_DATA_WIDTH-1:0] p_bus_resp;
	logic [BUS_TAG_WIDTH-1:0] p_bus_resptag;
	logic m_bus_reqcyc;
	logic m_bus_reqack;
	logic [BUS_DATA_WIDTH-1:0] m_bus_req;
	logic [BUS_TAG_WIDTH-1:0] m_bus_reqtag;
	logic m_bus_respcyc;
	logic m_bus_respack;
	logic [BUS_DATA_WIDTH-1:0] m_bus_resp;
	logic [BUS_TAG_WIDTH-1:0] m_bus_resptag;
	int fill_count;
	int wb_count;
	logic [BUS_DATA_WIDTH-1:0] last_wb_addr;
	int errors;
	int tests_run;
	int tests_failed;
	int errors_at_start;
	logic [BUS_DATA_WIDTH-1:0] shadow [logic [60:0]]; // beats written by the processor side

	tb_clock_gen i_clk_gen (.clk, .reset);

	set_cache #(.NUM_SETS(16)) i_dut (
		.clk, .reset,
		.p_bus_reqcyc, .p_bus_reqack, .p_bus_req, .p_bus_reqtag,
		.p_bus_respcyc, .p_bus_respack, .p_bus_resp, .p_bus_resptag,
		.m_bus_reqcyc, .m_bus_reqack, .m_bus_req, .m_bus_reqtag,
		.m_bus_respcyc, .m_bus_respack, .m_bus_resp, .m_bus_resptag
	);

	dram_model i_dram (
		.clk, .reset,
		.m_bus_reqcyc, .m_bus_reqack, .m_bus_req, .m_bus_reqtag,
		.m_bus_respcyc, .m_bus_respack, .m_bus_resp, .m_bus_resptag,
		.fill_count, .wb_count, .last_wb_addr
	);

	task automatic next_cycle();
		@(posedge clk);
		#10; // outputs settled, inputs change here
	endtask

	task automatic abort_run(input string what);
		$display("timed out after %0d cycles waiting for %s at %0t", TIMEOUT, what, $time);
		$display("STATUS: FAIL");
		$finish;
	endtask

	function automatic int total_failures();
		return errors + i_dut.i_assertions.failures;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else begin
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// memory rule: written beats, else line address xor beat number
	function automatic logic [63:0] expected_beat(input logic [63:0] addr, input int b);
		logic [60:0] key;
		key = {addr[63:6], 3'(b)};
		if (shadow.exists(key))
			return shadow[key];
		return {addr[63:6], 6'b0} ^ 64'(b);
	endfunction

	task automatic wait_reqack();
		int n;
		n = 0;
		while (!p_bus_reqack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!p_bus_reqack)
			abort_run("p_bus_reqack");
	endtask

	task automatic wait_respcyc(output int cycles);
		cycles = 0;
		while (!p_bus_respcyc && cycles < TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (!p_bus_respcyc)
			abort_run("p_bus_respcyc");
	endtask

	// exp_latency below 0 skips the hit timing check
	task automatic read_line(input logic [63:0] addr, input int max_delay, input int exp_latency);
		logic [BUS_TAG_WIDTH-1:0] tag;
		int lat;
		tag = {1'b1, 12'($urandom)};
		p_bus_req = addr;
		p_bus_reqtag = tag;
		p_bus_reqcyc = 1'b1;
		next_cycle();
		wait_reqack();
		p_bus_reqcyc = 1'b0;
		for (int b = 0; b < BEATS; b++) begin
			wait_respcyc(lat); // counts from the reqack cycle on beat 0
			if (b == 0 && exp_latency >= 0)
				check_value("p_bus_respcyc latency", 64'(lat), 64'(exp_latency));
			repeat ($urandom_range(0, max_delay)) next_cycle(); // late respack
			check_value("p_bus_resp", p_bus_resp, expected_beat(addr, b));
			check_value("p_bus_resptag", 64'(p_bus_resptag), 64'(tag));
			p_bus_respack = 1'b1;
			next_cycle();
			p_bus_respack = 1'b0;
		end
	endtask

	task automatic write_line(input logic [63:0] addr);
		logic [BUS_DATA_WIDTH-1:0] data;
		p_bus_req = addr;
		p_bus_reqtag = {1'b0, 12'($urandom)};
		p_bus_reqcyc = 1'b1;
		next_cycle();
		wait_reqack();
		for (int b = 0; b < BEATS; b++) begin
			data = {$urandom, $urandom};
			shadow[{addr[63:6], 3'(b)}] = data;
			p_bus_req = data;
			next_cycle();
			wait_reqack(); // one pulse per beat
		end
		p_bus_reqcyc = 1'b0;
	endtask

	task automatic begin_test();
		errors_at_start = total_failures();
		tests_run++;
	endtask

	task automatic finish_test(input string name);
		if (total_failures() == errors_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: failed", tests_run, name);
			tests_failed++;
		end
	endtask

	initial begin
		int n;
		int fills;
		int wbs;
		void'($urandom(32'ha52a_3be7));
		p_bus_reqcyc = 1'b0;
		p_bus_req = '0;
		p_bus_reqtag = '0;
		p_bus_respack = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		n = 0;
		while (reset !== 1'b0 && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (reset !== 1'b0)
			abort_run("reset release");
		next_cycle();

		begin_test();
		fills = fill_count;
		read_line(LINE_A1, 0, -1); // cold line, memory pattern
		check_value("dram fill count", 64'(fill_count - fills), 64'd1);
		finish_test("read miss");

		begin_test();
		fills = fill_count;
		wbs = wb_count;
		read_line(LINE_A1, 0, 2);
		check_value("dram fill count", 64'(fill_count - fills), 64'd0);
		check_value("dram writeback count", 64'(wb_count - wbs), 64'd0);
		finish_test("read hit");

		begin_test();
		fills = fill_count;
		wbs = wb_count;
		write_line(LINE_A1);
		read_line(LINE_A1, 0, 2);
		check_value("dram fill count", 64'(fill_count - fills), 64'd0);
		check_value("dram writeback count", 64'(wb_count - wbs), 64'd0);
		finish_test("write then read");

		begin_test();
		read_line(LINE_LA, 0, -1);
		read_line(LINE_LB, 0, -1);
		read_line(LINE_LA, 0, -1); // LB is now the LRU way
		read_line(LINE_LC, 0, -1);
		fills = fill_count;
		wbs = wb_count;
		read_line(LINE_LA, 0, -1);
		check_value("dram fill count", 64'(fill_count - fills), 64'd0);
		check_value("dram writeback count", 64'(wb_count - wbs), 64'd0);
		read_line(LINE_LB, 0, -1);
		check_value("dram fill count", 64'(fill_count - fills), 64'd1);
		finish_test("lru replacement");

		begin_test();
		write_line(LINE_WA); // allocates an empty way, dirty
		read_line(LINE_WX, 0, -1);
		wbs = wb_count;
		read_line(LINE_WY, 0, -1); // evicts WA
		check_value("dram writeback count", 64'(wb_count - wbs), 64'd1);
		check_value("dram writeback address", last_wb_addr, LINE_WA);
		fills = fill_count;
		read_line(LINE_WA, 0, -1); // data comes back from memory
		check_value("dram fill count", 64'(fill_count - fills), 64'd1);
		finish_test("dirty writeback");

		begin_test();
		read_line(LINE_A1, 5, -1);
		read_line(LINE_BP, 5, -1);
		finish_test("back-pressure");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_failures());
		if (total_failures() == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule
